// File: src/gemm_sig_cfg.svh
`ifndef GEMM_SIG_CFG_SVH
`define GEMM_SIG_CFG_SVH

// ########################################################################
// lane geometry
// ########################################################################

// result lanes watched by the signature unit
`define GEMM_SIG_LANES 8

// lanes handled by each half reducer
`define GEMM_SIG_HALF_LANES 4

// ########################################################################
// data widths
// ########################################################################

`define GEMM_SIG_WORD_W 32

// width each lane word is folded down to
`define GEMM_SIG_BYTE_W 8

// final nibble signature
`define GEMM_SIG_OUT_W 4

// sampling edge to data_valid: fold, 3 merge levels, nibble fold
`define GEMM_SIG_LATENCY 5

`endif

// File: src/gemm_sig_pkg.sv
`include "gemm_sig_cfg.svh"

package gemm_sig_pkg;

    // ####################################################################
    // data types
    // ####################################################################

    typedef logic [`GEMM_SIG_WORD_W-1:0] lane_word_t;

    // lane 0 sits in the low word
    typedef logic [`GEMM_SIG_LANES-1:0][`GEMM_SIG_WORD_W-1:0] lane_bus_t;

    typedef logic [`GEMM_SIG_HALF_LANES-1:0][`GEMM_SIG_WORD_W-1:0] half_bus_t;

    typedef logic [`GEMM_SIG_BYTE_W-1:0] fold_byte_t;

    typedef logic [`GEMM_SIG_OUT_W-1:0] signature_t;

    // ####################################################################
    // select/xor merge shared by every tree level
    // ####################################################################

    // empty pair gives zero, one side passes, both sides xor
    function automatic fold_byte_t merge_pair(
        input fold_byte_t a,
        input logic       a_valid,
        input fold_byte_t b,
        input logic       b_valid
    );
        fold_byte_t merged;
        case ({b_valid, a_valid})
            2'b01:   merged = a;
            2'b10:   merged = b;
            2'b11:   merged = a ^ b;
            default: merged = '0;
        endcase
        return merged;
    endfunction

endpackage

// File: src/lane_half_reducer.sv
`include "gemm_sig_cfg.svh"

module lane_half_reducer (
    input  logic                              ap_clk,
    input  logic                              rst,
    input  gemm_sig_pkg::half_bus_t           lane_din,
    input  logic [`GEMM_SIG_HALF_LANES-1:0]   lane_write,
    output gemm_sig_pkg::fold_byte_t          half_byte,
    output logic                              half_valid
);

    // xor of all bytes in one lane word
    function automatic gemm_sig_pkg::fold_byte_t fold_word(
        input gemm_sig_pkg::lane_word_t word
    );
        gemm_sig_pkg::fold_byte_t acc;
        acc = '0;
        for (int b = 0; b < `GEMM_SIG_WORD_W / `GEMM_SIG_BYTE_W; b++)
        begin
            acc = acc ^ word[b*`GEMM_SIG_BYTE_W +: `GEMM_SIG_BYTE_W];
        end
        return acc;
    endfunction

    // ####################################################################
    // stage 1: per-lane byte fold
    // ####################################################################

    gemm_sig_pkg::fold_byte_t [`GEMM_SIG_HALF_LANES-1:0]   fold_q;
    logic [`GEMM_SIG_HALF_LANES-1:0]                        fold_valid_q;

    always_ff @(posedge ap_clk)
    begin
        if (rst)
        begin
            fold_q       <= '0;
            fold_valid_q <= '0;
        end
        else
        begin
            for (int i = 0; i < `GEMM_SIG_HALF_LANES; i++)
            begin
                fold_q[i] <= fold_word(lane_din[i]);
            end
            // strobe travels alongside its byte
            fold_valid_q <= lane_write;
        end
    end

    // ####################################################################
    // stage 2: lanes 0/1 and 2/3 merged
    // ####################################################################

    gemm_sig_pkg::fold_byte_t [`GEMM_SIG_HALF_LANES/2-1:0] pair_q;
    logic [`GEMM_SIG_HALF_LANES/2-1:0]                      pair_valid_q;

    always_ff @(posedge ap_clk)
    begin
        if (rst)
        begin
            pair_q       <= '0;
            pair_valid_q <= '0;
        end
        else
        begin
            for (int j = 0; j < `GEMM_SIG_HALF_LANES / 2; j++)
            begin
                pair_q[j] <= gemm_sig_pkg::merge_pair(
                    fold_q[2*j],   fold_valid_q[2*j],
                    fold_q[2*j+1], fold_valid_q[2*j+1]
                );
                pair_valid_q[j] <= fold_valid_q[2*j] | fold_valid_q[2*j+1];
            end
        end
    end

    // ####################################################################
    // stage 3: the two pairs merged into the half result
    // ####################################################################

    always_ff @(posedge ap_clk)
    begin
        if (rst)
        begin
            half_byte  <= '0;
            half_valid <= 1'b0;
        end
        else
        begin
            half_byte <= gemm_sig_pkg::merge_pair(
                pair_q[0], pair_valid_q[0],
                pair_q[1], pair_valid_q[1]
            );
            half_valid <= |pair_valid_q;
        end
    end

endmodule

// File: src/signature_combiner.sv
`include "gemm_sig_cfg.svh"

module signature_combiner (
    input  logic                        ap_clk,
    input  logic                        rst,
    input  gemm_sig_pkg::fold_byte_t    lo_byte,
    input  logic                        lo_valid,
    input  gemm_sig_pkg::fold_byte_t    hi_byte,
    input  logic                        hi_valid,
    output gemm_sig_pkg::signature_t    data_out,
    output logic                        data_valid
);

    // ####################################################################
    // last merge level across the two halves
    // ####################################################################

    gemm_sig_pkg::fold_byte_t   merged_q;
    logic                       merged_valid_q;

    always_ff @(posedge ap_clk)
    begin
        if (rst)
        begin
            merged_q       <= '0;
            merged_valid_q <= 1'b0;
        end
        else
        begin
            merged_q       <= gemm_sig_pkg::merge_pair(lo_byte, lo_valid, hi_byte, hi_valid);
            merged_valid_q <= lo_valid | hi_valid;
        end
    end

    // ####################################################################
    // nibble fold to the output signature
    // ####################################################################

    gemm_sig_pkg::signature_t   nibble_fold;

    // merged byte is zero on an empty cycle, so data_out follows
    assign nibble_fold = merged_q[`GEMM_SIG_BYTE_W-1 -: `GEMM_SIG_OUT_W]
                       ^ merged_q[`GEMM_SIG_OUT_W-1:0];

    always_ff @(posedge ap_clk)
    begin
        if (rst)
        begin
            data_out   <= '0;
            data_valid <= 1'b0;
        end
        else
        begin
            data_out   <= nibble_fold;
            data_valid <= merged_valid_q;
        end
    end

endmodule

// File: src/gemm_sig_top.sv
`include "gemm_sig_cfg.svh"

module gemm_sig_top (
    input  logic                        ap_clk,
    input  logic                        rst,
    input  gemm_sig_pkg::lane_bus_t     lane_din,
    input  logic [`GEMM_SIG_LANES-1:0]  lane_write,
    output gemm_sig_pkg::signature_t    data_out,
    output logic                        data_valid
);

    // half results, 3 cycles after the sampling edge
    gemm_sig_pkg::fold_byte_t   lo_byte;
    logic                       lo_valid;
    gemm_sig_pkg::fold_byte_t   hi_byte;
    logic                       hi_valid;

    // ####################################################################
    // half reducers, lanes 0-3 and 4-7
    // ####################################################################

    lane_half_reducer u_half_lo (
        .ap_clk     (ap_clk),
        .rst        (rst),
        .lane_din   (lane_din[`GEMM_SIG_HALF_LANES-1:0]),
        .lane_write (lane_write[`GEMM_SIG_HALF_LANES-1:0]),
        .half_byte  (lo_byte),
        .half_valid (lo_valid)
    );

    lane_half_reducer u_half_hi (
        .ap_clk     (ap_clk),
        .rst        (rst),
        .lane_din   (lane_din[`GEMM_SIG_LANES-1:`GEMM_SIG_HALF_LANES]),
        .lane_write (lane_write[`GEMM_SIG_LANES-1:`GEMM_SIG_HALF_LANES]),
        .half_byte  (hi_byte),
        .half_valid (hi_valid)
    );

    // ####################################################################
    // final merge and nibble fold
    // ####################################################################

    signature_combiner u_combine (
        .ap_clk     (ap_clk),
        .rst        (rst),
        .lo_byte    (lo_byte),
        .lo_valid   (lo_valid),
        .hi_byte    (hi_byte),
        .hi_valid   (hi_valid),
        .data_out   (data_out),
        .data_valid (data_valid)
    );

endmodule

// File: verif/tb_gemm_sig.sv
`include "gemm_sig_cfg.svh"

module tb_gemm_sig;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int LATENCY = `GEMM_SIG_LATENCY;
    localparam int TIMEOUT = 20;
    localparam int BYTES_PER_WORD = `GEMM_SIG_WORD_W / `GEMM_SIG_BYTE_W;

    logic                           ap_clk;
    logic                           rst;
    gemm_sig_pkg::lane_bus_t        lane_din;
    logic [`GEMM_SIG_LANES-1:0]     lane_write;
    gemm_sig_pkg::signature_t       data_out;
    logic                           data_valid;

    logic [31:0]                    rng_state;

    // inputs for the cycle-by-cycle tests, one entry per input cycle
    gemm_sig_pkg::lane_bus_t        sched_din[$];
    logic [`GEMM_SIG_LANES-1:0]     sched_wr[$];

    gemm_sig_top UUT (
        .ap_clk     (ap_clk),
        .rst        (rst),
        .lane_din   (lane_din),
        .lane_write (lane_write),
        .data_out   (data_out),
        .data_valid (data_valid)
    );

    initial
    begin
        ap_clk = 1'b0;
        forever #5 ap_clk = ~ap_clk;
    end

    // ########################################################################
    // stimulus and reference model
    // ########################################################################

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic gemm_sig_pkg::lane_bus_t random_bus();
        gemm_sig_pkg::lane_bus_t bus;
        for (int i = 0; i < `GEMM_SIG_LANES; i++)
        begin
            bus[i] = xorshift32();
        end
        return bus;
    endfunction

    // xor of every byte of every strobed lane, then the two nibbles
    function automatic gemm_sig_pkg::signature_t model_signature(
        input gemm_sig_pkg::lane_bus_t    din,
        input logic [`GEMM_SIG_LANES-1:0] wr
    );
        gemm_sig_pkg::fold_byte_t acc;
        acc = '0;
        for (int i = 0; i < `GEMM_SIG_LANES; i++)
        begin
            if (wr[i])
            begin
                for (int b = 0; b < BYTES_PER_WORD; b++)
                begin
                    acc = acc ^ din[i][b*`GEMM_SIG_BYTE_W +: `GEMM_SIG_BYTE_W];
                end
            end
        end
        return acc[`GEMM_SIG_OUT_W +: `GEMM_SIG_OUT_W] ^ acc[0 +: `GEMM_SIG_OUT_W];
    endfunction

    // ########################################################################
    // compare tasks
    // ########################################################################

    task automatic check_signature(
        input string                    test_name,
        input gemm_sig_pkg::signature_t expected,
        input gemm_sig_pkg::signature_t actual
    );
        if (actual !== expected)
        begin
            $display("mismatch in %s: data_out expected %h, actual %h",
                     test_name, expected, actual);
            $display("Verification failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic check_valid(
        input string test_name,
        input logic  expected,
        input logic  actual
    );
        if (actual !== expected)
        begin
            $display("mismatch in %s: data_valid expected %b, actual %b",
                     test_name, expected, actual);
            $display("Verification failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic check_latency(
        input string test_name,
        input int    expected,
        input int    actual
    );
        if (actual != expected)
        begin
            $display("mismatch in %s: latency expected %0d, actual %0d",
                     test_name, expected, actual);
            $display("Verification failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic report_timeout(input string test_name);
        $display("data_valid never rose within %0d cycles in %s", TIMEOUT, test_name);
        $display("Verification failed");
        $fatal(1, "stopped on timeout");
    endtask

    // ########################################################################
    // drivers
    // ########################################################################

    task automatic drive_idle();
        lane_din   = '0;
        lane_write = '0;
    endtask

    // one strobed cycle, then wait for its result and the idle cycle after it
    task automatic apply_and_check(
        input string                      test_name,
        input gemm_sig_pkg::lane_bus_t    din,
        input logic [`GEMM_SIG_LANES-1:0] wr
    );
        int                       cycles;
        gemm_sig_pkg::signature_t expected;
        expected   = model_signature(din, wr);
        lane_din   = din;
        lane_write = wr;
        cycles     = 0;
        while (data_valid !== 1'b1)
        begin
            @(negedge ap_clk);
            cycles++;
            lane_write = '0;
            if (cycles > TIMEOUT)
            begin
                report_timeout(test_name);
            end
        end
        check_latency(test_name, LATENCY, cycles);
        check_signature(test_name, expected, data_out);
        @(negedge ap_clk);
        check_valid(test_name, 1'b0, data_valid);
        check_signature(test_name, '0, data_out);
    endtask

    // plays the queued inputs, one per cycle, checking each result in step
    task automatic run_schedule(input string test_name);
        int n;
        n = sched_din.size();
        for (int k = 0; k < n + LATENCY; k++)
        begin
            if (k >= LATENCY)
            begin
                check_valid(test_name, |sched_wr[k-LATENCY], data_valid);
                check_signature(test_name,
                                model_signature(sched_din[k-LATENCY], sched_wr[k-LATENCY]),
                                data_out);
            end
            if (k < n)
            begin
                lane_din   = sched_din[k];
                lane_write = sched_wr[k];
            end
            else
            begin
                drive_idle();
            end
            @(negedge ap_clk);
        end
        sched_din.delete();
        sched_wr.delete();
    endtask

    // ########################################################################
    // tests
    // ########################################################################

    task automatic test_reset_idle();
        for (int k = 0; k < 10; k++)
        begin
            @(negedge ap_clk);
            check_valid("reset_idle", 1'b0, data_valid);
            check_signature("reset_idle", '0, data_out);
        end
    endtask

    task automatic test_single_lane();
        logic [`GEMM_SIG_LANES-1:0] wr;
        for (int lane = 0; lane < `GEMM_SIG_LANES; lane++)
        begin
            wr       = '0;
            wr[lane] = 1'b1;
            apply_and_check($sformatf("single_lane_%0d", lane), random_bus(), wr);
        end
    endtask

    task automatic test_all_lanes();
        apply_and_check("all_lanes", random_bus(), '1);
    endtask

    task automatic test_partial_masks();
        apply_and_check("partial_lower", random_bus(), 8'h0F);
        apply_and_check("partial_upper", random_bus(), 8'hF0);
        apply_and_check("partial_odd", random_bus(), 8'hAA);
        apply_and_check("partial_mid", random_bus(), 8'h18);
    endtask

    task automatic test_stream();
        logic [31:0] rnd;
        for (int k = 0; k < 60; k++)
        begin
            rnd = xorshift32();
            sched_din.push_back(random_bus());
            // force some empty cycles into the stream
            if (k % 6 == 2)
            begin
                sched_wr.push_back('0);
            end
            else
            begin
                sched_wr.push_back(rnd[`GEMM_SIG_LANES-1:0]);
            end
        end
        run_schedule("stream");
    endtask

    task automatic test_gaps();
        sched_din.push_back(random_bus());
        sched_wr.push_back(8'hFF);
        sched_din.push_back(random_bus());
        sched_wr.push_back(8'h3C);
        sched_din.push_back(random_bus());
        sched_wr.push_back('0);
        sched_din.push_back(random_bus());
        sched_wr.push_back(8'h81);
        sched_din.push_back(random_bus());
        sched_wr.push_back(8'hFF);
        run_schedule("gaps");
    endtask

    initial
    begin
        rng_state = 32'd7;
        rst       = 1'b1;
        drive_idle();
        repeat (3) @(posedge ap_clk);
        @(negedge ap_clk);
        rst = 1'b0;

        test_reset_idle();
        test_single_lane();
        test_all_lanes();
        test_partial_masks();
        test_stream();
        test_gaps();

        $display("Verification passed");
        $finish;
    end

endmodule

// File: sources.f
+incdir+src
src/gemm_sig_pkg.sv
src/lane_half_reducer.sv
src/signature_combiner.sv
src/gemm_sig_top.sv
verif/tb_gemm_sig.sv

// File: run_sim.sh
#!/bin/sh
# build and run the signature unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    --top-module tb_gemm_sig \
    -f sources.f

# the simulation exits nonzero on a fatal error, the grep below decides
sim_out=$(./obj_dir/Vtb_gemm_sig 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "Verification passed"
then
    echo "run_sim: PASS"
    exit 0
else
    echo "run_sim: FAIL"
    exit 1
fi
